// ==== bench/fcpu_exec_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcpu_exec_chk (
   input wire logic                  ui_clk,
   input wire logic                  rst_i,
   input wire fcpu_pkg::exec_state_e state_i,
   input wire logic                  io_stb_i,
   input wire fcpu_pkg::byte_t       io_dat_i,
   input wire logic                  io_ack_i,
   input wire logic                  redirect_i,
   input wire logic                  instr_ready_i
);

   import fcpu_pkg::*;

   int fail_cnt = 0;

   // output request is held with the same byte until the transmitter takes it
   a_stb_hold: assert property (@(posedge ui_clk) disable iff (rst_i)
      io_stb_i && !io_ack_i |=> io_stb_i && $stable(io_dat_i))
      else begin
         fail_cnt++;
         $error("io strobe dropped or data changed before ack");
      end

   a_halt_quiet: assert property (@(posedge ui_clk) disable iff (rst_i)
      state_i == EX_HALTED |-> !$rose(io_stb_i))
      else begin
         fail_cnt++;
         $error("io strobe rose while halted");
      end

   // a stalled OUT holds back both the next instruction and any jump target
   a_wait_no_redirect: assert property (@(posedge ui_clk) disable iff (rst_i)
      state_i == EX_OUT_WAIT |-> !instr_ready_i && !redirect_i)
      else begin
         fail_cnt++;
         $error("redirect or instr_ready high during OUT_WAIT");
      end

endmodule

`default_nettype wire

// ==== bench/fcpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fcpu_params.svh"

module fcpu_tb;

   import fcpu_pkg::*;

   localparam int BIT       = `FCPU_UART_DIV;
   localparam int BYTE_WAIT = 60 * `FCPU_UART_DIV;

   logic       ui_clk;
   logic       rst_i;
   logic       uart_txd_in_i;
   logic       uart_rxd_out_o;
   logic [3:0] btn_i;
   logic [3:0] led_o;

   instr_t prog_q[$];
   byte_t  exp_q[$];
   int     errors;
   int     test_errs;
   int     tests;
   int     checks;

   fcpu_top i_dut (
      .ui_clk         (ui_clk),
      .rst_i          (rst_i),
      .uart_txd_in_i  (uart_txd_in_i),
      .uart_rxd_out_o (uart_rxd_out_o),
      .btn_i          (btn_i),
      .led_o          (led_o)
   );

   bind fcpu_exec fcpu_exec_chk i_chk (
      .ui_clk        (ui_clk),
      .rst_i         (rst_i),
      .state_i       (state_q),
      .io_stb_i      (io_stb_o),
      .io_dat_i      (io_dat_o),
      .io_ack_i      (io_ack_i),
      .redirect_i    (redirect_o),
      .instr_ready_i (instr_ready_o)
   );

   always #10 ui_clk = ~ui_clk;

   function automatic instr_t encode(input op_e op, input byte_t imm);
      return {op, 4'h0, imm};
   endfunction

   // leaves the caller 2 ns after a rising edge
   task automatic idle_cycles(input int n);
      repeat (n) @(posedge ui_clk);
      #2;
   endtask

   task automatic send_byte(input byte_t b);
      int i;
      uart_txd_in_i = 1'b0;
      idle_cycles(BIT);
      for (i = 0; i < 8; i++) begin
         uart_txd_in_i = b[i];
         idle_cycles(BIT);
      end
      uart_txd_in_i = 1'b1;
      idle_cycles(BIT);
   endtask

   // low byte first, then a few cycles for the receiver to finish
   task automatic load_program();
      idle_cycles(2);
      foreach (prog_q[k]) begin
         send_byte(prog_q[k][7:0]);
         send_byte(prog_q[k][15:8]);
      end
      prog_q.delete();
      idle_cycles(4);
   endtask

   task automatic pulse_start();
      idle_cycles(1);
      btn_i[0] = 1'b1;
      idle_cycles(1);
      btn_i[0] = 1'b0;
   endtask

   // ok stays low on timeout or on a low stop bit
   task automatic recv_byte(input int limit, output byte_t b, output bit ok);
      int n;
      int i;
      ok = 1'b0;
      b  = '0;
      n  = 0;
      @(negedge ui_clk);
      while (uart_rxd_out_o !== 1'b0 && n < limit) begin
         @(negedge ui_clk);
         n++;
      end
      if (uart_rxd_out_o === 1'b0) begin
         repeat (BIT / 2) @(negedge ui_clk);
         if (uart_rxd_out_o === 1'b0) begin
            for (i = 0; i < 8; i++) begin
               repeat (BIT) @(negedge ui_clk);
               b[i] = uart_rxd_out_o;
            end
            repeat (BIT) @(negedge ui_clk);
            ok = (uart_rxd_out_o === 1'b1);
         end
      end
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      checks++;
      assert (act === exp) else begin
         $display("ERR %s expected %02h actual %02h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic expect_output(input string name);
      byte_t got;
      bit    ok;
      int    idx;
      idx = 0;
      ok  = 1'b1;
      while (exp_q.size() > 0 && ok) begin
         recv_byte(BYTE_WAIT, got, ok);
         checks++;
         assert (ok) else begin
            $display("test %s: output byte %0d never arrived as a frame", name, idx);
            test_errs++;
         end
         if (ok)
            check_byte(name, exp_q[0], got);
         void'(exp_q.pop_front());
         idx++;
      end
      exp_q.delete();
   endtask

   task automatic expect_silence(input string name);
      byte_t got;
      bit    ok;
      recv_byte(BYTE_WAIT, got, ok);
      checks++;
      assert (!ok) else begin
         $display("test %s: an extra byte %02h appeared on the serial line", name, got);
         test_errs++;
      end
   endtask

   task automatic wait_halted(input string name);
      int n;
      n = 0;
      while (led_o[1] !== 1'b1 && n < BYTE_WAIT) begin
         @(negedge ui_clk);
         n++;
      end
      checks++;
      assert (led_o[1] === 1'b1) else begin
         $display("test %s: the core never reached the halted state", name);
         test_errs++;
      end
      // only the halted LED is lit
      if (led_o[1] === 1'b1) begin
         checks++;
         assert (led_o === 4'h2) else begin
            $display("ERR %s expected %h actual %h", name, 4'h2, led_o);
            test_errs++;
         end
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      errors += test_errs;
      if (test_errs == 0)
         $display("test %-12s ok", name);
      else
         $display("test %-12s %0d errors", name, test_errs);
      test_errs = 0;
   endtask

   task automatic reset_and_single_out();
      byte_t v;
      int    n;
      v = byte_t'($urandom);
      for (n = 0; n < 4 * BIT; n++) begin
         @(negedge ui_clk);
         checks += 2;
         assert (led_o === 4'h0) else begin
            $display("ERR reset expected %h actual %h", 4'h0, led_o);
            test_errs++;
         end
         assert (uart_rxd_out_o === 1'b1) else begin
            $display("test reset: serial output left the idle level");
            test_errs++;
         end
      end
      prog_q.push_back(encode(OP_LDI, v));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      pulse_start();
      // core is running right after the start pulse
      checks++;
      assert (led_o === 4'h1) else begin
         $display("ERR reset expected %h actual %h", 4'h1, led_o);
         test_errs++;
      end
      exp_q.push_back(v);
      expect_output("reset");
      wait_halted("reset");
      report_test("reset");
   endtask

   task automatic arith_wrap();
      int a;
      int b;
      int s;
      int c;
      // sum crosses 255 and the difference goes below 0
      a = 128 + $urandom % 128;
      b = 128 + $urandom % 128;
      s = (a + b) % 256;
      c = s + 1 + $urandom % (255 - s);
      prog_q.push_back(encode(OP_LDI, byte_t'(a)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_ADDI, byte_t'(b)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_SUBI, byte_t'(c)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      pulse_start();
      exp_q.push_back(byte_t'(a));
      exp_q.push_back(byte_t'(s));
      exp_q.push_back(byte_t'((s - c + 256) % 256));
      expect_output("arith");
      wait_halted("arith");
      report_test("arith");
   endtask

   task automatic countdown_branch();
      int v;
      prog_q.push_back(encode(OP_LDI, 8'd3));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_SUBI, 8'd1));
      prog_q.push_back(encode(OP_JNZ, 8'd1));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      pulse_start();
      for (v = 3; v > 0; v--)
         exp_q.push_back(byte_t'(v));
      expect_output("branch");
      expect_silence("branch");
      wait_halted("branch");
      report_test("branch");
   endtask

   task automatic out_backpressure();
      int acc;
      int d1;
      int d2;
      int d3;
      acc = $urandom % 256;
      d1  = 1 + $urandom % 255;
      d2  = 1 + $urandom % 255;
      d3  = 1 + $urandom % 255;
      prog_q.push_back(encode(OP_LDI, byte_t'(acc)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_ADDI, byte_t'(d1)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_ADDI, byte_t'(d2)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_SUBI, byte_t'(d3)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      pulse_start();
      exp_q.push_back(byte_t'(acc));
      acc = (acc + d1) % 256;
      exp_q.push_back(byte_t'(acc));
      acc = (acc + d2) % 256;
      exp_q.push_back(byte_t'(acc));
      acc = (acc - d3 + 256) % 256;
      exp_q.push_back(byte_t'(acc));
      expect_output("backpress");
      wait_halted("backpress");
      report_test("backpress");
   endtask

   task automatic restart_reload();
      int a;
      int b;
      int run;
      a = $urandom % 256;
      b = $urandom % 256;
      prog_q.push_back(encode(OP_LDI, byte_t'(a)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_SUBI, byte_t'(b)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      // second run comes from the same RAM contents
      for (run = 0; run < 2; run++) begin
         pulse_start();
         exp_q.push_back(byte_t'(a));
         exp_q.push_back(byte_t'((a - b + 256) % 256));
         expect_output("restart");
         wait_halted("restart");
      end
      prog_q.push_back(encode(OP_LDI, byte_t'(a ^ 8'h5a)));
      prog_q.push_back(encode(OP_OUT, 8'h00));
      prog_q.push_back(encode(OP_HALT, 8'h00));
      load_program();
      pulse_start();
      exp_q.push_back(byte_t'(a ^ 8'h5a));
      expect_output("restart");
      expect_silence("restart");
      wait_halted("restart");
      report_test("restart");
   endtask

   initial begin
      ui_clk        = 1'b0;
      rst_i         = 1'b1;
      uart_txd_in_i = 1'b1;
      btn_i         = 4'h0;
      errors        = 0;
      test_errs     = 0;
      tests         = 0;
      checks        = 0;
      void'($urandom(32'h5264_9686));
      idle_cycles(5);
      rst_i = 1'b0;
      reset_and_single_out();
      arith_wrap();
      countdown_branch();
      out_backpressure();
      restart_reload();
      errors += i_dut.exec_inst.i_chk.fail_cnt;
      $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/cram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fcpu_params.svh"

module cram (
   input  wire logic             ui_clk,
   input  wire logic             rst_i,
   input  wire fcpu_pkg::byte_t  rx_data_i,
   input  wire logic             rx_valid_i,
   input  wire logic             restart_i,
   input  wire logic             wb_cyc_i,
   input  wire logic             wb_stb_i,
   input  wire fcpu_pkg::pc_t    wb_adr_i,
   output fcpu_pkg::instr_t      wb_dat_o,
   output logic                  wb_ack_o
);

   import fcpu_pkg::*;

   instr_t mem_q [`FCPU_CRAM_DEPTH];
   byte_t  lo_q;
   logic   hi_phase_q;
   pc_t    wptr_q;
   logic   wr_en;

   // second byte of a pair completes the word
   assign wr_en = rx_valid_i && hi_phase_q && !rst_i && !restart_i;

   always_ff @(posedge ui_clk) begin
      if (rst_i || restart_i) begin
         hi_phase_q <= 1'b0;
         wptr_q     <= '0;
      end else if (rx_valid_i) begin
         hi_phase_q <= !hi_phase_q;
         if (!hi_phase_q)
            lo_q <= rx_data_i;
         else
            wptr_q <= wptr_q + 8'd1;
      end
   end

   always_ff @(posedge ui_clk) begin
      if (wr_en)
         mem_q[wptr_q] <= {rx_data_i, lo_q};
      wb_dat_o <= mem_q[wb_adr_i];
   end

   // single cycle ack even while the master still holds stb
   always_ff @(posedge ui_clk) begin
      if (rst_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
   end

endmodule

`default_nettype wire

// ==== hw/fcpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fcpu_params.svh"

module fcpu_exec (
   input  wire logic             ui_clk,
   input  wire logic             rst_i,
   input  wire logic             start_i,
   input  wire fcpu_pkg::instr_t instr_i,
   input  wire logic             instr_valid_i,
   output logic                  instr_ready_o,
   output logic                  redirect_o,
   output fcpu_pkg::pc_t         redirect_pc_o,
   output logic                  io_cyc_o,
   output logic                  io_stb_o,
   output fcpu_pkg::byte_t       io_dat_o,
   input  wire logic             io_ack_i,
   output logic                  running_o,
   output logic                  halted_o
);

   import fcpu_pkg::*;

   exec_state_e state_q;
   instr_t      ir_q;
   logic        ir_valid_q;
   byte_t       acc_q;
   byte_t       imm;
   byte_t       io_dat_q;
   logic        io_stb_q;
   op_e         op;
   logic        fire;
   logic        taken;
   logic        stall;
   logic        accept;

   assign op    = op_e'(ir_q[`FCPU_OP_MSB:`FCPU_OP_LSB]);
   assign imm   = ir_q[`FCPU_IMM_MSB:0];
   assign fire  = (state_q == EX_RUN) && ir_valid_q;
   assign taken = fire && (op == OP_JNZ) && (acc_q != '0);

   // no new instruction behind an OUT, a HALT or a taken jump
   assign stall         = fire && ((op == OP_OUT) || (op == OP_HALT) || taken);
   assign instr_ready_o = (state_q == EX_RUN) && !stall;
   assign accept        = instr_valid_i && instr_ready_o;

   assign redirect_o    = taken;
   assign redirect_pc_o = imm;

   always_ff @(posedge ui_clk) begin
      if (rst_i) begin
         state_q    <= EX_IDLE;
         ir_valid_q <= 1'b0;
         io_stb_q   <= 1'b0;
      end else if (start_i) begin
         state_q    <= EX_RUN;
         ir_valid_q <= 1'b0;
         io_stb_q   <= 1'b0;
      end else begin
         if (accept)
            ir_valid_q <= 1'b1;
         else if (fire)
            ir_valid_q <= 1'b0;
         case (state_q)
            EX_RUN: begin
               if (fire && op == OP_OUT) begin
                  io_stb_q <= 1'b1;
                  state_q  <= EX_OUT_WAIT;
               end else if (fire && op == OP_HALT) begin
                  state_q <= EX_HALTED;
               end
            end
            EX_OUT_WAIT: begin
               if (io_ack_i) begin
                  io_stb_q <= 1'b0;
                  state_q  <= EX_RUN;
               end
            end
            default: ;
         endcase
      end
   end

   // accumulator wraps modulo 256
   always_ff @(posedge ui_clk) begin
      if (accept)
         ir_q <= instr_i;
      if (start_i) begin
         acc_q <= '0;
      end else if (fire) begin
         case (op)
            OP_LDI:  acc_q <= imm;
            OP_ADDI: acc_q <= acc_q + imm;
            OP_SUBI: acc_q <= acc_q - imm;
            OP_OUT:  io_dat_q <= acc_q;
            default: ;
         endcase
      end
   end

   assign io_cyc_o  = io_stb_q;
   assign io_stb_o  = io_stb_q;
   assign io_dat_o  = io_dat_q;
   assign running_o = (state_q == EX_RUN) || (state_q == EX_OUT_WAIT);
   assign halted_o  = (state_q == EX_HALTED);

endmodule

`default_nettype wire

// ==== hw/fcpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcpu_fetch (
   input  wire logic             ui_clk,
   input  wire logic             rst_i,
   input  wire logic             start_i,
   input  wire logic             redirect_i,
   input  wire fcpu_pkg::pc_t    redirect_pc_i,
   output logic                  wb_cyc_o,
   output logic                  wb_stb_o,
   output fcpu_pkg::pc_t         wb_adr_o,
   input  wire fcpu_pkg::instr_t wb_dat_i,
   input  wire logic             wb_ack_i,
   output fcpu_pkg::instr_t      instr_o,
   output fcpu_pkg::pc_t         pc_o,
   output logic                  instr_valid_o,
   input  wire logic             instr_ready_i
);

   import fcpu_pkg::*;

   pc_t  pc_q;
   logic active_q;
   logic busy_q;
   logic discard_q;
   logic valid_q;
   logic flush;
   logic take;
   logic issue;
   logic land;

   assign flush = start_i || redirect_i;
   assign take  = valid_q && instr_ready_i;
   // holding register must be empty, or emptied this cycle
   assign issue = active_q && !busy_q && (!valid_q || take) && !flush;
   assign land  = busy_q && wb_ack_i && !discard_q;

   always_ff @(posedge ui_clk) begin
      if (rst_i) begin
         active_q  <= 1'b0;
         busy_q    <= 1'b0;
         discard_q <= 1'b0;
         valid_q   <= 1'b0;
         pc_q      <= '0;
      end else begin
         if (start_i)
            active_q <= 1'b1;
         if (busy_q && wb_ack_i) begin
            busy_q    <= 1'b0;
            discard_q <= 1'b0;
         end else if (issue) begin
            busy_q <= 1'b1;
         end
         if (flush) begin
            valid_q <= 1'b0;
            pc_q    <= start_i ? '0 : redirect_pc_i;
            // read still outstanding, drop its data when it lands
            if (busy_q && !wb_ack_i)
               discard_q <= 1'b1;
         end else if (land) begin
            valid_q <= 1'b1;
         end else if (take) begin
            valid_q <= 1'b0;
         end
         if (issue)
            pc_q <= pc_q + 8'd1;
      end
   end

   always_ff @(posedge ui_clk) begin
      if (issue)
         wb_adr_o <= pc_q;
      if (land && !flush) begin
         instr_o <= wb_dat_i;
         pc_o    <= wb_adr_o;
      end
   end

   assign wb_cyc_o      = busy_q;
   assign wb_stb_o      = busy_q;
   assign instr_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hw/fcpu_pkg.sv ====
`default_nettype none

package fcpu_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] instr_t;
   typedef logic [7:0]  pc_t;

   // codes not listed here execute as NOP
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_LDI  = 4'h1,
      OP_ADDI = 4'h2,
      OP_SUBI = 4'h3,
      OP_JNZ  = 4'h4,
      OP_OUT  = 4'h5,
      OP_HALT = 4'hf
   } op_e;

   typedef enum logic [1:0] {
      EX_IDLE,
      EX_RUN,
      EX_OUT_WAIT,
      EX_HALTED
   } exec_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

endpackage

`default_nettype wire

// ==== hw/fcpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcpu_top (
   input  wire logic       ui_clk,
   input  wire logic       rst_i,
   input  wire logic       uart_txd_in_i,
   output logic            uart_rxd_out_o,
   input  wire logic [3:0] btn_i,
   output logic [3:0]      led_o
);

   import fcpu_pkg::*;

   byte_t  rx_data;
   logic   rx_valid;
   logic   cram_cyc;
   logic   cram_stb;
   pc_t    cram_adr;
   instr_t cram_dat;
   logic   cram_ack;
   instr_t instr;
   logic   instr_valid;
   logic   instr_ready;
   logic   redirect;
   pc_t    redirect_pc;
   logic   io_cyc;
   logic   io_stb;
   byte_t  io_dat;
   logic   io_ack;
   logic   running;
   logic   halted;

   uart_rx uart_rx_inst (
      .ui_clk  (ui_clk),
      .rst_i   (rst_i),
      .rxd_i   (uart_txd_in_i),
      .data_o  (rx_data),
      .valid_o (rx_valid)
   );

   // btn 0 restarts both the loader and the core
   cram cram_inst (
      .ui_clk     (ui_clk),
      .rst_i      (rst_i),
      .rx_data_i  (rx_data),
      .rx_valid_i (rx_valid),
      .restart_i  (btn_i[0]),
      .wb_cyc_i   (cram_cyc),
      .wb_stb_i   (cram_stb),
      .wb_adr_i   (cram_adr),
      .wb_dat_o   (cram_dat),
      .wb_ack_o   (cram_ack)
   );

   fcpu_fetch fetch_inst (
      .ui_clk        (ui_clk),
      .rst_i         (rst_i),
      .start_i       (btn_i[0]),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .wb_cyc_o      (cram_cyc),
      .wb_stb_o      (cram_stb),
      .wb_adr_o      (cram_adr),
      .wb_dat_i      (cram_dat),
      .wb_ack_i      (cram_ack),
      .instr_o       (instr),
      .pc_o          (),
      .instr_valid_o (instr_valid),
      .instr_ready_i (instr_ready)
   );

   fcpu_exec exec_inst (
      .ui_clk        (ui_clk),
      .rst_i         (rst_i),
      .start_i       (btn_i[0]),
      .instr_i       (instr),
      .instr_valid_i (instr_valid),
      .instr_ready_o (instr_ready),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc),
      .io_cyc_o      (io_cyc),
      .io_stb_o      (io_stb),
      .io_dat_o      (io_dat),
      .io_ack_i      (io_ack),
      .running_o     (running),
      .halted_o      (halted)
   );

   uart_tx uart_tx_inst (
      .ui_clk   (ui_clk),
      .rst_i    (rst_i),
      .wb_cyc_i (io_cyc),
      .wb_stb_i (io_stb),
      .wb_dat_i (io_dat),
      .wb_ack_o (io_ack),
      .txd_o    (uart_rxd_out_o)
   );

   assign led_o = {2'b00, halted, running};

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fcpu_params.svh"

module uart_rx (
   input  wire logic      ui_clk,
   input  wire logic      rst_i,
   input  wire logic      rxd_i,
   output fcpu_pkg::byte_t data_o,
   output logic           valid_o
);

   import fcpu_pkg::*;

   localparam logic [15:0] BIT_TICKS  = 16'(`FCPU_UART_DIV - 1);
   localparam logic [15:0] HALF_TICKS = 16'(`FCPU_UART_DIV / 2 - 1);

   logic        rxd_meta;
   logic        rxd_sync;
   logic        busy_q;
   logic [15:0] cnt_q;
   logic [3:0]  bit_q;
   byte_t       shift_q;

   // line idles high
   always_ff @(posedge ui_clk) begin
      if (rst_i) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd_i;
         rxd_sync <= rxd_meta;
      end
   end

   // bit 0 is the start bit, 1..8 data, 9 stop
   always_ff @(posedge ui_clk) begin
      valid_o <= 1'b0;
      if (rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         bit_q  <= '0;
      end else if (!busy_q) begin
         if (!rxd_sync) begin
            busy_q <= 1'b1;
            cnt_q  <= HALF_TICKS;
            bit_q  <= '0;
         end
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 16'd1;
      end else begin
         cnt_q <= BIT_TICKS;
         bit_q <= bit_q + 4'd1;
         if (bit_q == 4'd0) begin
            // start bit gone high again at its middle
            if (rxd_sync)
               busy_q <= 1'b0;
         end else if (bit_q == 4'd9) begin
            busy_q  <= 1'b0;
            valid_o <= rxd_sync;
         end else begin
            shift_q <= {rxd_sync, shift_q[7:1]};
         end
      end
   end

   assign data_o = shift_q;

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fcpu_params.svh"

module uart_tx (
   input  wire logic            ui_clk,
   input  wire logic            rst_i,
   input  wire logic            wb_cyc_i,
   input  wire logic            wb_stb_i,
   input  wire fcpu_pkg::byte_t wb_dat_i,
   output logic                 wb_ack_o,
   output logic                 txd_o
);

   import fcpu_pkg::*;

   localparam logic [15:0] BIT_TICKS = 16'(`FCPU_UART_DIV - 1);

   tx_state_e   state_q;
   logic [15:0] cnt_q;
   logic [2:0]  bit_q;
   byte_t       shift_q;

   // byte is taken on the same edge that closes the bus cycle
   assign wb_ack_o = wb_cyc_i && wb_stb_i && (state_q == TX_IDLE);

   always_ff @(posedge ui_clk) begin
      if (rst_i) begin
         state_q <= TX_IDLE;
         txd_o   <= 1'b1;
         cnt_q   <= '0;
         bit_q   <= '0;
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 16'd1;
      end else begin
         case (state_q)
            TX_IDLE: begin
               if (wb_ack_o) begin
                  shift_q <= wb_dat_i;
                  txd_o   <= 1'b0;
                  cnt_q   <= BIT_TICKS;
                  state_q <= TX_START;
               end
            end
            TX_START: begin
               txd_o   <= shift_q[0];
               shift_q <= shift_q >> 1;
               bit_q   <= '0;
               cnt_q   <= BIT_TICKS;
               state_q <= TX_DATA;
            end
            TX_DATA: begin
               cnt_q <= BIT_TICKS;
               if (bit_q == 3'd7) begin
                  txd_o   <= 1'b1;
                  state_q <= TX_STOP;
               end else begin
                  txd_o   <= shift_q[0];
                  shift_q <= shift_q >> 1;
                  bit_q   <= bit_q + 3'd1;
               end
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== include/fcpu_params.svh ====
`ifndef FCPU_PARAMS_SVH
`define FCPU_PARAMS_SVH

// clock cycles per serial bit
`define FCPU_UART_DIV 8

// code RAM words, one instruction each
`define FCPU_CRAM_DEPTH 256

// instruction fields, bits 11..8 are don't care
`define FCPU_OP_MSB 15
`define FCPU_OP_LSB 12
`define FCPU_IMM_MSB 7

`endif

// ==== sim.f ====
+incdir+include
hw/fcpu_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cram.sv
hw/fcpu_fetch.sv
hw/fcpu_exec.sv
hw/fcpu_top.sv
bench/fcpu_exec_chk.sv
bench/fcpu_tb.sv
